/* hw/ahb_sys_pkg.sv */
// Sizes, memory map constants, PMA/HTRANS/master state enums and bus structs
`default_nettype none

package ahb_sys_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes and memory map
  ////////////////////////////////////////////////////////////////////////////

  // Data and physical address width
  localparam int xlen = 32;
  localparam int plen = 32;

  // RAM region, word addressed inside the slave
  localparam logic [plen-1:0] ram_base  = 32'h8000_0000;
  localparam int              ram_words = 256;
  localparam int              ram_aw    = $clog2(ram_words);

  // Host interface word
  localparam logic [plen-1:0] tohost_addr = 32'h8000_1000;

  // Request queue
  localparam int fifo_depth = 4;
  localparam int fifo_aw    = $clog2(fifo_depth);

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Region attribute, none means access fault
  typedef enum logic [1:0] {
    pma_none,
    pma_main,
    pma_io
  } pma_e;

  // Only the two transfer types this master issues
  typedef enum logic [1:0] {
    idle   = 2'b00,
    nonseq = 2'b10
  } htrans_e;

  // Bus master sequencing
  typedef enum logic [1:0] {
    m_idle,
    m_addr,
    m_data,
    m_resp
  } mst_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////////////

  // One queue entry
  typedef struct packed {
    logic            we;
    logic [plen-1:0] addr;
    logic [xlen-1:0] wdata;
  } dbg_req_t;

  // Read result back to the debug port
  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic            err;
  } dbg_rsp_t;

  typedef struct packed {
    logic            hsel;
    logic [plen-1:0] haddr;
    logic [xlen-1:0] hwdata;
    logic            hwrite;
    htrans_e         htrans;
  } ahb_m2s_t;

  typedef struct packed {
    logic [xlen-1:0] hrdata;
    logic            hready;
    logic            hresp;
  } ahb_s2m_t;

endpackage

`default_nettype wire

/* hw/pma_check.sv */
// Fixed PMA table: RAM region and TOHOST word decode to access attribute
`timescale 1ns/1ps
`default_nettype none

module pma_check import ahb_sys_pkg::*; (
  input  wire logic [plen-1:0] addr,
  output pma_e                 attr
);

  logic [plen-1:0] ram_off;
  logic            aligned;
  logic            in_ram;
  logic            is_tohost;

  // Word accesses only
  assign aligned = (addr[1:0] == 2'b00);

  // Below the base wraps to a large offset and misses
  assign ram_off = addr - ram_base;
  assign in_ram  = (ram_off < plen'(ram_words * 4));

  // Exact word match, any byte offset is a fault
  assign is_tohost = (addr == tohost_addr);

  always_comb begin
    attr = pma_none;
    if (is_tohost)             attr = pma_io;
    else if (in_ram && aligned) attr = pma_main;
  end

endmodule

`default_nettype wire

/* hw/dbg_req_port.sv */
// Debug port front end: four-phase strobe to queue push, read result return
`timescale 1ns/1ps
`default_nettype none

module dbg_req_port import ahb_sys_pkg::*; (
  input  wire logic            HCLK,
  input  wire logic            rst_n,
  input  wire logic            dbg_strb,
  input  wire logic            dbg_we,
  input  wire logic [plen-1:0] dbg_addr,
  input  wire logic [xlen-1:0] dbg_dati,
  output logic      [xlen-1:0] dbg_dato,
  output logic                 dbg_ack,
  output logic                 dbg_err,
  output logic                 enq,
  output dbg_req_t             enq_data,
  input  wire logic            full,
  input  wire logic            rsp_valid,
  input  dbg_rsp_t             rsp
);

  // Idle, blocked on full queue, waiting for read data, ack held
  typedef enum logic [1:0] {p_idle, p_push, p_rsp, p_ack} port_state_e;

  port_state_e     state_q, state_d;
  logic [xlen-1:0] dato_q;
  logic            err_q;

  // Requester keeps these stable while strb is high
  assign enq_data = '{we: dbg_we, addr: dbg_addr, wdata: dbg_dati};
  assign enq      = dbg_strb && (state_q == p_idle || state_q == p_push);

  always_comb begin
    state_d = state_q;
    case (state_q)
      p_idle: if (dbg_strb) begin
        if (full) state_d = p_push;
        else      state_d = dbg_we ? p_ack : p_rsp;
      end
      // Writes ack on push, reads after the bus returns
      p_push:  if (!full) state_d = dbg_we ? p_ack : p_rsp;
      p_rsp:   if (rsp_valid) state_d = p_ack;
      p_ack:   if (!dbg_strb) state_d = p_idle;
      default: state_d = p_idle;
    endcase
  end

  always_ff @(posedge HCLK or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= p_idle;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == p_rsp && rsp_valid) err_q <= rsp.err;
      else if (enq && !full && dbg_we)   err_q <= 1'b0;
    end
  end

  // Read data holder
  always_ff @(posedge HCLK) begin
    if (state_q == p_rsp && rsp_valid) dato_q <= rsp.rdata;
  end

  assign dbg_ack  = (state_q == p_ack);
  assign dbg_dato = dato_q;
  assign dbg_err  = err_q;

endmodule

`default_nettype wire

/* hw/req_fifo.sv */
// Four-entry in-order request queue with registered head entry
`timescale 1ns/1ps
`default_nettype none

module req_fifo import ahb_sys_pkg::*; (
  input  wire logic HCLK,
  input  wire logic rst_n,
  input  wire logic enq,
  input  dbg_req_t  enq_data,
  output logic      full,
  output dbg_req_t  deq_data,
  output logic      empty,
  input  wire logic deq
);

  dbg_req_t           mem [fifo_depth];
  logic [fifo_aw-1:0] wr_ptr, rd_ptr;
  logic [fifo_aw:0]   count;
  logic               push, pop;

  // Qualified strobes
  assign push = enq && !full;
  assign pop  = deq && !empty;

  assign full  = (count == (fifo_aw+1)'(fifo_depth));
  assign empty = (count == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge HCLK or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge HCLK) begin
    if (push) mem[wr_ptr] <= enq_data;
  end

  // Head straight out of the register file
  assign deq_data = mem[rd_ptr];

endmodule

`default_nettype wire

/* hw/ahb3_master.sv */
// AHB3-Lite master: queue drain, PMA fault check, address and data phases
`timescale 1ns/1ps
`default_nettype none

module ahb3_master import ahb_sys_pkg::*; (
  input  wire logic HCLK,
  input  wire logic rst_n,
  input  dbg_req_t  deq_data,
  input  wire logic empty,
  output logic      deq,
  output logic      rsp_valid,
  output dbg_rsp_t  rsp,
  output logic      wr_fault,
  output ahb_m2s_t  m2s,
  input  ahb_s2m_t  s2m
);

  mst_state_e      state_q, state_d;
  dbg_req_t        req_q;
  logic [xlen-1:0] rdata_q;
  logic            err_q;
  pma_e            attr;
  logic            pma_fault;
  logic            bus_req;

  // Attribute of the request being served
  pma_check pma_check_i (
    .addr ( req_q.addr ),
    .attr ( attr       )
  );

  // Main and IO both allow word read/write, only none faults
  assign pma_fault = (attr == pma_none);
  assign bus_req   = (state_q == m_addr) && !pma_fault;

  // Pop one entry per transfer
  assign deq = (state_q == m_idle) && !empty;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      m_idle: if (!empty) state_d = m_addr;
      m_addr: begin
        if (pma_fault)       state_d = m_resp;  // bus skipped
        else if (s2m.hready) state_d = m_data;
      end
      m_data:  if (s2m.hready) state_d = m_resp;
      default: state_d = m_idle;
    endcase
  end

  always_ff @(posedge HCLK or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= m_idle;
      wr_fault <= 1'b0;
    end else begin
      state_q <= state_d;
      // Sticky until reset
      if (state_q == m_resp && req_q.we && err_q) wr_fault <= 1'b1;
    end
  end

  // Request and result holders
  always_ff @(posedge HCLK) begin
    if (deq) req_q <= deq_data;
    if (state_q == m_addr && pma_fault) begin
      err_q   <= 1'b1;
      rdata_q <= '0;
    end else if (state_q == m_data && s2m.hready) begin
      err_q   <= s2m.hresp;
      rdata_q <= s2m.hresp ? '0 : s2m.hrdata;
    end
  end

  // Single NONSEQ per request, data follows from the held entry
  always_comb begin
    m2s.hsel   = bus_req;
    m2s.haddr  = req_q.addr;
    m2s.hwdata = req_q.wdata;
    m2s.hwrite = req_q.we;
    m2s.htrans = bus_req ? nonseq : idle;
  end

  // Reads only, one cycle in m_resp
  assign rsp_valid = (state_q == m_resp) && !req_q.we;
  assign rsp       = '{rdata: rdata_q, err: err_q};

endmodule

`default_nettype wire

/* hw/ahb3_spram.sv */
// AHB3-Lite slave: 256-word single-port RAM plus TOHOST register
`timescale 1ns/1ps
`default_nettype none

module ahb3_spram import ahb_sys_pkg::*; (
  input  wire logic            HCLK,
  input  wire logic            rst_n,
  input  ahb_m2s_t             m2s,
  output ahb_s2m_t             s2m,
  output logic      [xlen-1:0] tohost
);

  logic [xlen-1:0]   mem [ram_words];
  logic [xlen-1:0]   tohost_q;
  logic              accept;
  logic              ram_hit, io_hit;
  logic              dp_valid, dp_write;
  logic              dp_hit, dp_io;
  logic [plen-1:0]   dp_addr;
  logic [ram_aw-1:0] dp_idx;

  ////////////////////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////////////////////

  // Always ready, so every selected NONSEQ is taken
  assign accept  = m2s.hsel && (m2s.htrans == nonseq);
  assign ram_hit = (m2s.haddr[plen-1:ram_aw+2] == ram_base[plen-1:ram_aw+2]);
  assign io_hit  = (m2s.haddr == tohost_addr);

  always_ff @(posedge HCLK or negedge rst_n) begin
    if (!rst_n) begin
      dp_valid <= 1'b0;
      dp_write <= 1'b0;
    end else begin
      dp_valid <= accept;
      dp_write <= accept && m2s.hwrite;
    end
  end

  always_ff @(posedge HCLK) begin
    if (accept) begin
      dp_addr <= m2s.haddr;
      dp_hit  <= ram_hit || io_hit;
      dp_io   <= io_hit;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////////////////////////////////////////

  assign dp_idx = dp_addr[ram_aw+1:2];

  always_ff @(posedge HCLK) begin
    if (dp_write && dp_hit && !dp_io) mem[dp_idx] <= m2s.hwdata;
  end

  // Host mailbox
  always_ff @(posedge HCLK or negedge rst_n) begin
    if (!rst_n)                      tohost_q <= '0;
    else if (dp_write && dp_io)      tohost_q <= m2s.hwdata;
  end

  // Unmapped address answers with an error
  assign s2m.hrdata = dp_io ? tohost_q : mem[dp_idx];
  assign s2m.hready = 1'b1;
  assign s2m.hresp  = dp_valid && !dp_hit;

  assign tohost = tohost_q;

endmodule

`default_nettype wire

/* hw/ahb_sys_top.sv */
// System top: debug port, request queue, AHB3 master and RAM slave
`timescale 1ns/1ps
`default_nettype none

module ahb_sys_top import ahb_sys_pkg::*; (
  input  wire logic            HCLK,
  input  wire logic            rst_n,
  input  wire logic            dbg_strb,
  input  wire logic            dbg_we,
  input  wire logic [plen-1:0] dbg_addr,
  input  wire logic [xlen-1:0] dbg_dati,
  output logic      [xlen-1:0] dbg_dato,
  output logic                 dbg_ack,
  output logic                 dbg_err,
  output logic                 wr_fault,
  output logic      [xlen-1:0] tohost
);

  // Port to queue
  logic     enq, full;
  dbg_req_t enq_data;

  // Queue to master
  logic     deq, empty;
  dbg_req_t deq_data;

  // Read results and bus
  logic     rsp_valid;
  dbg_rsp_t rsp;
  ahb_m2s_t m2s;
  ahb_s2m_t s2m;

  dbg_req_port dbg_req_port_i (
    .HCLK, .rst_n,
    .dbg_strb, .dbg_we, .dbg_addr, .dbg_dati,
    .dbg_dato, .dbg_ack, .dbg_err,
    .enq, .enq_data, .full,
    .rsp_valid, .rsp
  );

  req_fifo req_fifo_i (
    .HCLK, .rst_n,
    .enq, .enq_data, .full,
    .deq_data, .empty, .deq
  );

  ahb3_master ahb3_master_i (
    .HCLK, .rst_n,
    .deq_data, .empty, .deq,
    .rsp_valid, .rsp, .wr_fault,
    .m2s, .s2m
  );

  ahb3_spram ahb3_spram_i (
    .HCLK, .rst_n,
    .m2s, .s2m, .tohost
  );

endmodule

`default_nettype wire

/* verif/ahb_sys_assert.sv */
// Concurrent assertions on AHB address phase, HSEL/HTRANS and read response pulse
`timescale 1ns/1ps
`default_nettype none

module ahb_sys_assert import ahb_sys_pkg::*; (
  input wire logic     HCLK,
  input wire logic     rst_n,
  input wire ahb_m2s_t m2s,
  input wire ahb_s2m_t s2m,
  input wire logic     rsp_valid
);

  // Address phase frozen during wait states
  addr_hold: assert property (@(posedge HCLK) disable iff (!rst_n)
    (m2s.htrans == nonseq && !s2m.hready) |=> ($stable(m2s.haddr) && $stable(m2s.htrans)))
    else $error("haddr or htrans changed while hready low");

  // No transfer without select
  sel_trans: assert property (@(posedge HCLK) disable iff (!rst_n)
    (m2s.htrans == nonseq) |-> m2s.hsel)
    else $error("htrans nonseq with hsel low");

  // Read result is a single pulse
  rsp_pulse: assert property (@(posedge HCLK) disable iff (!rst_n)
    rsp_valid |=> !rsp_valid)
    else $error("rsp_valid held longer than one cycle");

endmodule

bind ahb3_master ahb_sys_assert ahb_sys_assert_i (
  .HCLK, .rst_n, .m2s, .s2m, .rsp_valid
);

`default_nettype wire

/* verif/tb_ahb_sys.sv */
// Testbench with clock, reset, stimulus table, reference model, debug port driver and compare tasks
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_sys import ahb_sys_pkg::*; ();

  // One table row with expected values from the reference model
  typedef struct packed {
    logic            we;
    logic [plen-1:0] addr;
    logic [xlen-1:0] wdata;
    dbg_rsp_t        exp_rsp;
    logic [xlen-1:0] exp_tohost;
    logic            exp_wr_fault;
  } entry_t;

  logic            HCLK;
  logic            rst_n;
  logic            dbg_strb;
  logic            dbg_we;
  logic [plen-1:0] dbg_addr;
  logic [xlen-1:0] dbg_dati;
  logic [xlen-1:0] dbg_dato;
  logic            dbg_ack;
  logic            dbg_err;
  logic            wr_fault;
  logic [xlen-1:0] tohost;

  // Stimulus table and reference model
  entry_t          stim_q[$];
  string           name_q[$];
  logic [xlen-1:0] model_ram [ram_words];
  logic [xlen-1:0] model_tohost;
  logic            model_wr_fault;
  logic [31:0]     lcg_state;
  int              err_cnt;
  int              pass_cnt;
  int              fail_cnt;

  ahb_sys_top ahb_sys_top_i (
    .HCLK, .rst_n,
    .dbg_strb, .dbg_we, .dbg_addr, .dbg_dati,
    .dbg_dato, .dbg_ack, .dbg_err,
    .wr_fault, .tohost
  );

  initial begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Model and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Aligned word inside the RAM window or the exact TOHOST word
  task automatic add_entry(input string name, input logic we,
                           input logic [plen-1:0] addr, input logic [xlen-1:0] wdata);
    entry_t          e;
    logic            ram_ok;
    logic            io_ok;
    ram_ok = (addr >= ram_base) && (addr < ram_base + plen'(ram_words * 4)) &&
             (addr[1:0] == 2'b00);
    io_ok  = (addr == tohost_addr);
    e.we    = we;
    e.addr  = addr;
    e.wdata = wdata;
    e.exp_rsp = '{rdata: '0, err: 1'b0};
    if (we) begin
      if (ram_ok)     model_ram[addr[ram_aw+1:2]] = wdata;
      else if (io_ok) model_tohost = wdata;
      else            model_wr_fault = 1'b1;
    end else begin
      // Faulting reads give zero data
      if (ram_ok)     e.exp_rsp.rdata = model_ram[addr[ram_aw+1:2]];
      else if (io_ok) e.exp_rsp.rdata = model_tohost;
      else            e.exp_rsp.err = 1'b1;
    end
    e.exp_tohost   = model_tohost;
    e.exp_wr_fault = model_wr_fault;
    stim_q.push_back(e);
    name_q.push_back(name);
  endtask

  // Ack sampled on the falling edge
  task automatic wait_ack(input logic level, output bit ok);
    int n;
    n = 0;
    @(negedge HCLK);
    while (dbg_ack !== level && n < 200) begin
      @(negedge HCLK);
      n++;
    end
    ok = (dbg_ack === level);
  endtask

  // Full four-phase cycle on the debug port
  task automatic run_access(input entry_t e, output dbg_rsp_t got, output bit ok);
    bit up_ok;
    @(posedge HCLK);
    dbg_strb <= 1'b1;
    dbg_we   <= e.we;
    dbg_addr <= e.addr;
    dbg_dati <= e.wdata;
    wait_ack(1'b1, up_ok);
    got.rdata = dbg_dato;
    got.err   = dbg_err;
    @(posedge HCLK);
    dbg_strb <= 1'b0;
    wait_ack(1'b0, ok);
    ok = ok && up_ok;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_rsp(input string name, input dbg_rsp_t exp, input dbg_rsp_t act);
    if (act !== exp) begin
      $display("ERR %s rsp expected rdata=%h err=%b actual rdata=%h err=%b",
               name, exp.rdata, exp.err, act.rdata, act.err);
      err_cnt++;
    end
  endtask

  task automatic check_word(input string name, input string what,
                            input logic [xlen-1:0] exp, input logic [xlen-1:0] act);
    if (act !== exp) begin
      $display("ERR %s %s expected %h actual %h", name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input string what,
                            input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s %s expected %b actual %b", name, what, exp, act);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [plen-1:0] rt_addr [8];
    logic [xlen-1:0] r;
    dbg_rsp_t        got;
    bit              acked;
    int              errs_before;
    rst_n          = 1'b0;
    dbg_strb       = 1'b0;
    dbg_we         = 1'b0;
    dbg_addr       = '0;
    dbg_dati       = '0;
    model_tohost   = '0;
    model_wr_fault = 1'b0;
    lcg_state      = 32'd54;
    err_cnt        = 0;
    pass_cnt       = 0;
    fail_cnt       = 0;

    // RAM round trip at random word addresses
    for (int k = 0; k < 8; k++) begin
      r = lcg_next();
      rt_addr[k] = ram_base + plen'({r[ram_aw+15:16], 2'b00});
      add_entry($sformatf("ram_wr_%0d", k), 1'b1, rt_addr[k], lcg_next());
    end
    for (int k = 0; k < 8; k++)
      add_entry($sformatf("ram_rd_%0d", k), 1'b0, rt_addr[k], '0);
    // Posted writes then an immediate read of the last value
    for (int k = 0; k < 3; k++)
      add_entry($sformatf("po_wr_%0d", k), 1'b1, ram_base + 32'h40, lcg_next());
    add_entry("po_rd", 1'b0, ram_base + 32'h40, '0);
    // Host mailbox
    add_entry("th_wr", 1'b1, tohost_addr, lcg_next());
    add_entry("th_rd", 1'b0, tohost_addr, '0);
    // Read faults
    add_entry("rf_out_rd", 1'b0, 32'h9000_0000, '0);
    add_entry("rf_mis_io_rd", 1'b0, tohost_addr + 32'd2, '0);
    add_entry("rf_low_rd", 1'b0, 32'h7fff_fffc, '0);
    // Write faults around a known RAM word
    add_entry("wf_base_wr", 1'b1, ram_base, lcg_next());
    add_entry("wf_out_wr", 1'b1, ram_base + 32'h400, lcg_next());
    add_entry("wf_mis_wr", 1'b1, ram_base + 32'd2, lcg_next());
    add_entry("wf_base_rd", 1'b0, ram_base, '0);
    // Burst of writes into the queue and read back
    for (int k = 0; k < 5; k++)
      add_entry($sformatf("bp_wr_%0d", k), 1'b1, ram_base + 32'h200 + 32'(4 * k), lcg_next());
    for (int k = 0; k < 5; k++)
      add_entry($sformatf("bp_rd_%0d", k), 1'b0, ram_base + 32'h200 + 32'(4 * k), '0);

    repeat (3) @(posedge HCLK);
    rst_n <= 1'b1;

    for (int i = 0; i < stim_q.size(); i++) begin
      errs_before = err_cnt;
      run_access(stim_q[i], got, acked);
      if (!acked) begin
        $display("%s no ack from debug port", name_q[i]);
        fail_cnt++;
        break;
      end
      // Outputs checked once each read completes
      if (!stim_q[i].we) begin
        check_rsp(name_q[i], stim_q[i].exp_rsp, got);
        check_word(name_q[i], "tohost", stim_q[i].exp_tohost, tohost);
        check_flag(name_q[i], "wr_fault", stim_q[i].exp_wr_fault, wr_fault);
      end
      if (err_cnt == errs_before) begin
        pass_cnt++;
        $display("%s ok", name_q[i]);
      end else begin
        fail_cnt++;
        $display("%s mismatch", name_q[i]);
      end
    end

    $display("tests %0d, passed %0d, failed %0d", stim_q.size(), pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hw/ahb_sys_pkg.sv
hw/pma_check.sv
hw/dbg_req_port.sv
hw/req_fifo.sv
hw/ahb3_master.sv
hw/ahb3_spram.sv
hw/ahb_sys_top.sv
verif/ahb_sys_assert.sv
verif/tb_ahb_sys.sv

/* Makefile */
OBJ = obj_dir

sim:
	verilator --binary --timing --assert --top-module tb_ahb_sys -f sim.f -o tb_sim
	./$(OBJ)/tb_sim > sim.log 2>&1; cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf $(OBJ) sim.log

.PHONY: sim clean
